// File: logic/multiplierPkg.sv
package multiplierPkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Register and bus width, wide enough for an exact 8x8 product
	localparam int dataWidth = 16;
	// Operand width at the top-level inputs
	localparam int operandWidth = 8;
	// Register select, write decoder and read multiplexers
	localparam int regSelWidth = 3;
	// ALU operation select
	localparam int aluOpWidth = 4;
	// Shifter operation select
	localparam int shiftOpWidth = 2;

	// ========================================================================
	// Word types
	// ========================================================================

	typedef logic [dataWidth-1:0] dataWord;
	typedef logic [operandWidth-1:0] operandWord;
	typedef logic [regSelWidth-1:0] regSel;
	typedef logic [aluOpWidth-1:0] aluOp;
	typedef logic [shiftOpWidth-1:0] shiftOp;

	// ========================================================================
	// Register select codes
	// ========================================================================

	// General registers
	localparam regSel regGen0 = 3'd0;
	localparam regSel regGen1 = 3'd1;
	localparam regSel regGen2 = 3'd2;
	localparam regSel regGen3 = 3'd3;
	// Fixed registers, loaded from the operands
	localparam regSel regFix0 = 3'd4;
	localparam regSel regFix1 = 3'd5;
	// No write, or zero on the bus
	localparam regSel regNone = 3'd7;

	// ========================================================================
	// ALU operation codes
	// ========================================================================

	// Bus A straight through
	localparam aluOp aluPass = 4'b0000;
	localparam aluOp aluAnd = 4'b0010;
	localparam aluOp aluAdd = 4'b1000;
	// Bus A plus one
	localparam aluOp aluInc = 4'b1010;
	// Waiting, result follows bus A
	localparam aluOp aluIdle = 4'b1111;

	// ========================================================================
	// Shifter operation codes
	// ========================================================================

	localparam shiftOp shiftLeft = 2'b01;
	localparam shiftOp shiftRight = 2'b10;
	// 00 holds as well
	localparam shiftOp shiftHold = 2'b11;

endpackage

// File: logic/registerBank.sv
`timescale 1ns/100ps

module registerBank (
	input logic SC_STATEMACHINE_CLOCK_50,
	input logic SC_STATEMACHINE_Reset_InHigh,
	input logic loadOperands,
	input multiplierPkg::operandWord operandA,
	input multiplierPkg::operandWord operandB,
	input multiplierPkg::regSel writeSel,
	input multiplierPkg::regSel busASel,
	input multiplierPkg::regSel busBSel,
	input multiplierPkg::dataWord busC,
	output multiplierPkg::dataWord busA,
	output multiplierPkg::dataWord busB,
	output multiplierPkg::dataWord product
);

	// ========================================================================
	// Register file
	// ========================================================================

	// Four general registers, then the two fixed ones
	multiplierPkg::dataWord regFile [0:multiplierPkg::regFix1];

	// Zero padding for the operands
	localparam int padWidth = multiplierPkg::dataWidth - multiplierPkg::operandWidth;

	// Shared read multiplexer, zero on any spare code
	function automatic multiplierPkg::dataWord readPort(input multiplierPkg::regSel sel);
		if (sel <= multiplierPkg::regFix1)
		begin
			return regFile[sel];
		end
		return '0;
	endfunction

	// Operand load wins over the bus C write
	always_ff @(posedge SC_STATEMACHINE_CLOCK_50, posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			for (int i = 0; i <= multiplierPkg::regFix1; i++)
			begin
				regFile[i] <= '0;
			end
		end
		else if (loadOperands)
		begin
			// Fresh run, accumulator and mask start from zero
			for (int i = multiplierPkg::regGen0; i <= multiplierPkg::regGen3; i++)
			begin
				regFile[i] <= '0;
			end
			regFile[multiplierPkg::regFix0] <= {{padWidth{1'b0}}, operandA};
			regFile[multiplierPkg::regFix1] <= {{padWidth{1'b0}}, operandB};
		end
		else if (writeSel <= multiplierPkg::regFix1)
		begin
			// Write decoder, regNone and spare codes write nothing
			regFile[writeSel] <= busC;
		end
	end

	// ========================================================================
	// Read side
	// ========================================================================

	always_comb
	begin
		busA = readPort(busASel);
		busB = readPort(busBSel);
	end

	// Accumulator is the result
	assign product = regFile[multiplierPkg::regGen3];

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps

module alu (
	input logic SC_STATEMACHINE_CLOCK_50,
	input logic SC_STATEMACHINE_Reset_InHigh,
	input multiplierPkg::aluOp aluSel,
	input multiplierPkg::dataWord busA,
	input multiplierPkg::dataWord busB,
	output multiplierPkg::dataWord aluResult,
	output logic zero
);

	// ========================================================================
	// Operations
	// ========================================================================

	always_comb
	begin
		case (aluSel)
			multiplierPkg::aluPass: aluResult = busA;
			// Masks out the multiplier bit under test
			multiplierPkg::aluAnd: aluResult = busA & busB;
			// Wraps modulo 2^dataWidth
			multiplierPkg::aluAdd: aluResult = busA + busB;
			// Builds the one-bit mask from a cleared register
			multiplierPkg::aluInc: aluResult = busA + 1'b1;
			// aluIdle and dropped codes
			default: aluResult = busA;
		endcase
	end

	// ========================================================================
	// Zero flag
	// ========================================================================

	// Samples every cycle, sequencer reads it one cycle later
	always_ff @(posedge SC_STATEMACHINE_CLOCK_50, posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			zero <= 1'b0;
		end
		else
		begin
			zero <= (aluResult == '0);
		end
	end

endmodule

// File: logic/shiftRegister.sv
`timescale 1ns/100ps

module shiftRegister (
	input logic SC_STATEMACHINE_CLOCK_50,
	input logic SC_STATEMACHINE_Reset_InHigh,
	input logic shifterLoadLow,
	input multiplierPkg::shiftOp shiftSel,
	input multiplierPkg::dataWord dataIn,
	output multiplierPkg::dataWord busC
);

	localparam int msb = multiplierPkg::dataWidth - 1;

	// ========================================================================
	// Bus C register
	// ========================================================================

	always_ff @(posedge SC_STATEMACHINE_CLOCK_50, posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			busC <= '0;
		end
		else if (!shifterLoadLow)
		begin
			// Capture the ALU result
			busC <= dataIn;
		end
		else
		begin
			case (shiftSel)
				// Multiplicand doubles
				multiplierPkg::shiftLeft: busC <= {busC[msb-1:0], 1'b0};
				// Next multiplier bit into the LSB
				multiplierPkg::shiftRight: busC <= {1'b0, busC[msb:1]};
				// shiftHold and 00
				default: busC <= busC;
			endcase
		end
	end

endmodule

// File: logic/sequencer.sv
`timescale 1ns/100ps

module sequencer (
	input logic SC_STATEMACHINE_CLOCK_50,
	input logic SC_STATEMACHINE_Reset_InHigh,
	input logic start,
	input logic zero,
	output logic loadOperands,
	output multiplierPkg::regSel writeSel,
	output multiplierPkg::regSel busASel,
	output multiplierPkg::regSel busBSel,
	output multiplierPkg::aluOp aluSel,
	output logic shifterLoadLow,
	output multiplierPkg::shiftOp shiftSel,
	output logic done
);

	// Moves are select, load, write; shifts add a shift cycle before the write
	typedef enum logic [4:0] {
		stIdle, stLoad,
		stMovMulSel, stMovMulLoad, stMovMulWrite,
		stMovMcandSel, stMovMcandLoad, stMovMcandWrite,
		stMaskSel, stMaskLoad, stMaskWrite,
		stCheckZero0, stCheckZero1, stCheckLsb0, stCheckLsb1,
		stAddSel, stAddLoad, stAddWrite,
		stShlSel, stShlLoad, stShlShift, stShlWrite,
		stShrSel, stShrLoad, stShrShift, stShrWrite,
		stEnd
	} seqState;

	seqState state;
	seqState nextState;

	// ========================================================================
	// Next state
	// ========================================================================

	always_comb
	begin
		case (state)
			// Start only taken when not busy
			stIdle: nextState = start ? stLoad : stIdle;
			stEnd: nextState = start ? stLoad : stEnd;
			stLoad: nextState = stMovMulSel;
			// Copies and mask setup
			stMovMulSel: nextState = stMovMulLoad;
			stMovMulLoad: nextState = stMovMulWrite;
			stMovMulWrite: nextState = stMovMcandSel;
			stMovMcandSel: nextState = stMovMcandLoad;
			stMovMcandLoad: nextState = stMovMcandWrite;
			stMovMcandWrite: nextState = stMaskSel;
			stMaskSel: nextState = stMaskLoad;
			stMaskLoad: nextState = stMaskWrite;
			stMaskWrite: nextState = stCheckZero0;
			// Multiplier exhausted ends the run
			stCheckZero0: nextState = stCheckZero1;
			stCheckZero1: nextState = zero ? stEnd : stCheckLsb0;
			// Bit clear skips the add
			stCheckLsb0: nextState = stCheckLsb1;
			stCheckLsb1: nextState = zero ? stShlSel : stAddSel;
			stAddSel: nextState = stAddLoad;
			stAddLoad: nextState = stAddWrite;
			stAddWrite: nextState = stShlSel;
			stShlSel: nextState = stShlLoad;
			stShlLoad: nextState = stShlShift;
			stShlShift: nextState = stShlWrite;
			stShlWrite: nextState = stShrSel;
			stShrSel: nextState = stShrLoad;
			stShrLoad: nextState = stShrShift;
			stShrShift: nextState = stShrWrite;
			// Loop back to the zero test
			stShrWrite: nextState = stCheckZero0;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge SC_STATEMACHINE_CLOCK_50, posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			state <= stIdle;
		end
		else
		begin
			state <= nextState;
		end
	end

	// ========================================================================
	// Control word decode
	// ========================================================================

	always_comb
	begin
		// Quiet control word
		loadOperands = 1'b0;
		writeSel = multiplierPkg::regNone;
		busASel = multiplierPkg::regNone;
		busBSel = multiplierPkg::regNone;
		aluSel = multiplierPkg::aluIdle;
		shiftSel = multiplierPkg::shiftHold;
		done = 1'b0;
		case (state)
			stLoad: loadOperands = 1'b1;
			// Multiplier into gen2
			stMovMulSel, stMovMulLoad:
			begin
				busASel = multiplierPkg::regFix1;
				aluSel = multiplierPkg::aluPass;
			end
			// Multiplicand into gen1
			stMovMcandSel, stMovMcandLoad:
			begin
				busASel = multiplierPkg::regFix0;
				aluSel = multiplierPkg::aluPass;
			end
			// Mask in gen0 goes from zero to one
			stMaskSel, stMaskLoad:
			begin
				busASel = multiplierPkg::regGen0;
				aluSel = multiplierPkg::aluInc;
			end
			// Multiplier through the ALU, also the source of the right shift
			stCheckZero0, stCheckZero1, stShrSel, stShrLoad:
			begin
				busASel = multiplierPkg::regGen2;
				aluSel = multiplierPkg::aluPass;
			end
			stCheckLsb0, stCheckLsb1:
			begin
				busASel = multiplierPkg::regGen2;
				busBSel = multiplierPkg::regGen0;
				aluSel = multiplierPkg::aluAnd;
			end
			// Accumulate
			stAddSel, stAddLoad:
			begin
				busASel = multiplierPkg::regGen3;
				busBSel = multiplierPkg::regGen1;
				aluSel = multiplierPkg::aluAdd;
			end
			stShlSel, stShlLoad:
			begin
				busASel = multiplierPkg::regGen1;
				aluSel = multiplierPkg::aluPass;
			end
			stShlShift:
			begin
				busASel = multiplierPkg::regGen1;
				aluSel = multiplierPkg::aluPass;
				shiftSel = multiplierPkg::shiftLeft;
			end
			stShrShift:
			begin
				busASel = multiplierPkg::regGen2;
				aluSel = multiplierPkg::aluPass;
				shiftSel = multiplierPkg::shiftRight;
			end
			// Write-back cycles
			stMovMulWrite, stShrWrite: writeSel = multiplierPkg::regGen2;
			stMovMcandWrite, stShlWrite: writeSel = multiplierPkg::regGen1;
			stMaskWrite: writeSel = multiplierPkg::regGen0;
			stAddWrite: writeSel = multiplierPkg::regGen3;
			stEnd: done = 1'b1;
			default: loadOperands = 1'b0;
		endcase
	end

	// Shifter captures the ALU result in the middle cycle of every move
	assign shifterLoadLow = !(state inside {stMovMulLoad, stMovMcandLoad, stMaskLoad,
		stAddLoad, stShlLoad, stShrLoad});

endmodule

// File: logic/multiplierTop.sv
`timescale 1ns/100ps

module multiplierTop (
	input logic SC_STATEMACHINE_CLOCK_50,
	input logic SC_STATEMACHINE_Reset_InHigh,
	input logic start,
	input multiplierPkg::operandWord operandA,
	input multiplierPkg::operandWord operandB,
	output multiplierPkg::dataWord product,
	output logic done
);

	// ========================================================================
	// Control word
	// ========================================================================

	logic loadOperands;
	multiplierPkg::regSel writeSel;
	multiplierPkg::regSel busASel;
	multiplierPkg::regSel busBSel;
	multiplierPkg::aluOp aluSel;
	logic shifterLoadLow;
	multiplierPkg::shiftOp shiftSel;

	// Datapath buses and flag
	multiplierPkg::dataWord busA;
	multiplierPkg::dataWord busB;
	multiplierPkg::dataWord busC;
	multiplierPkg::dataWord aluResult;
	logic zero;

	// ========================================================================
	// Instances
	// ========================================================================

	sequencer sequencer_i (
		.SC_STATEMACHINE_CLOCK_50(SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh(SC_STATEMACHINE_Reset_InHigh),
		.start(start), .zero(zero), .loadOperands(loadOperands),
		.writeSel(writeSel), .busASel(busASel), .busBSel(busBSel),
		.aluSel(aluSel), .shifterLoadLow(shifterLoadLow),
		.shiftSel(shiftSel), .done(done)
	);

	// Registers, write from bus C and read onto buses A and B
	registerBank registerBank_i (
		.SC_STATEMACHINE_CLOCK_50(SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh(SC_STATEMACHINE_Reset_InHigh),
		.loadOperands(loadOperands), .operandA(operandA), .operandB(operandB),
		.writeSel(writeSel), .busASel(busASel), .busBSel(busBSel),
		.busC(busC), .busA(busA), .busB(busB), .product(product)
	);

	alu alu_i (
		.SC_STATEMACHINE_CLOCK_50(SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh(SC_STATEMACHINE_Reset_InHigh),
		.aluSel(aluSel), .busA(busA), .busB(busB),
		.aluResult(aluResult), .zero(zero)
	);

	// Drives bus C
	shiftRegister shiftRegister_i (
		.SC_STATEMACHINE_CLOCK_50(SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh(SC_STATEMACHINE_Reset_InHigh),
		.shifterLoadLow(shifterLoadLow), .shiftSel(shiftSel),
		.dataIn(aluResult), .busC(busC)
	);

endmodule

// File: dv/multiplierTop_assertions.sv
`timescale 1ns/100ps

module multiplierTop_assertions (
	input logic SC_STATEMACHINE_CLOCK_50,
	input logic SC_STATEMACHINE_Reset_InHigh,
	input logic loadOperands,
	input multiplierPkg::regSel writeSel,
	input logic shifterLoadLow,
	input multiplierPkg::shiftOp shiftSel,
	input logic done
);

	// Failures so far, read at the end of the run
	int violationCount = 0;

	// ========================================================================
	// Control word rules
	// ========================================================================

	// Shifter capture and register write never share a cycle
	noWriteInLoad: assert property (@(posedge SC_STATEMACHINE_CLOCK_50)
		disable iff (SC_STATEMACHINE_Reset_InHigh)
		!shifterLoadLow |-> writeSel == multiplierPkg::regNone)
	else
	begin
		violationCount++;
		$error("register write selected in a shifter load cycle");
	end

	// Load and shift are separate cycles of a move
	noShiftInLoad: assert property (@(posedge SC_STATEMACHINE_CLOCK_50)
		disable iff (SC_STATEMACHINE_Reset_InHigh)
		!shifterLoadLow |->
		(shiftSel != multiplierPkg::shiftLeft && shiftSel != multiplierPkg::shiftRight))
	else
	begin
		violationCount++;
		$error("shift selected in a shifter load cycle");
	end

	// A fresh run drops done
	doneLowAfterLoad: assert property (@(posedge SC_STATEMACHINE_CLOCK_50)
		disable iff (SC_STATEMACHINE_Reset_InHigh)
		loadOperands |=> !done)
	else
	begin
		violationCount++;
		$error("done still high after an operand load");
	end

endmodule

bind sequencer multiplierTop_assertions controlChecks_i (
	.SC_STATEMACHINE_CLOCK_50(SC_STATEMACHINE_CLOCK_50),
	.SC_STATEMACHINE_Reset_InHigh(SC_STATEMACHINE_Reset_InHigh),
	.loadOperands(loadOperands), .writeSel(writeSel),
	.shifterLoadLow(shifterLoadLow), .shiftSel(shiftSel), .done(done)
);

// File: dv/multiplierTb.sv
`timescale 1ns/100ps

module multiplierTb;

	// ========================================================================
	// Timing and run lengths
	// ========================================================================

	localparam int clockPeriod = 100;
	// Worst run about 8 loop passes of 15 cycles plus setup
	localparam int maxRunCycles = 240;
	// Directed, random, back-to-back and busy runs rounded up
	localparam int runCount = 50;
	localparam int randomPairs = 40;

	logic SC_STATEMACHINE_CLOCK_50 = 1'b0;
	logic SC_STATEMACHINE_Reset_InHigh;
	logic start;
	multiplierPkg::operandWord operandA;
	multiplierPkg::operandWord operandB;
	multiplierPkg::dataWord product;
	logic done;

	// Expected products and names in start order
	multiplierPkg::dataWord expectedQ[$];
	string nameQ[$];
	int valueErrors = 0;
	int timingErrors = 0;
	int doneRises = 0;
	logic doneLast = 1'b0;
	integer seed = 47;

	multiplierTop dut_i (
		.SC_STATEMACHINE_CLOCK_50(SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh(SC_STATEMACHINE_Reset_InHigh),
		.start(start), .operandA(operandA), .operandB(operandB),
		.product(product), .done(done)
	);

	always
	begin
		#(clockPeriod / 2);
		SC_STATEMACHINE_CLOCK_50 = !SC_STATEMACHINE_CLOCK_50;
	end

	// ========================================================================
	// Reference model and compare tasks
	// ========================================================================

	// Exact product of the zero-extended operands
	function automatic multiplierPkg::dataWord referenceProduct(
		input multiplierPkg::operandWord a, input multiplierPkg::operandWord b);
		multiplierPkg::dataWord wideA;
		multiplierPkg::dataWord wideB;
		wideA = multiplierPkg::dataWord'(a);
		wideB = multiplierPkg::dataWord'(b);
		return wideA * wideB;
	endfunction

	task automatic checkProduct(input string name, input multiplierPkg::dataWord expected,
		input multiplierPkg::dataWord actual);
		if (actual !== expected)
		begin
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkDone(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %s: expected done %b, actual %b", name, expected, actual);
			valueErrors++;
		end
	endtask

	// One-cycle start pulse from the falling edge
	task automatic launchRun(input string name, input multiplierPkg::operandWord a,
		input multiplierPkg::operandWord b);
		operandA = a;
		operandB = b;
		start = 1'b1;
		expectedQ.push_back(referenceProduct(a, b));
		nameQ.push_back(name);
		@(negedge SC_STATEMACHINE_CLOCK_50);
		start = 1'b0;
	endtask

	task automatic waitDone(input string name);
		int cycles;
		cycles = 0;
		while (!done && cycles < maxRunCycles)
		begin
			@(negedge SC_STATEMACHINE_CLOCK_50);
			cycles++;
		end
		if (!done)
		begin
			$display("Run %s did not raise done within %0d cycles", name, maxRunCycles);
			timingErrors++;
		end
	endtask

	task automatic runProduct(input string name, input multiplierPkg::operandWord a,
		input multiplierPkg::operandWord b);
		launchRun(name, a, b);
		waitDone(name);
	endtask

	// Compare on each rising done at the falling edge
	always @(negedge SC_STATEMACHINE_CLOCK_50)
	begin
		if (done && !doneLast)
		begin
			doneRises++;
			if (expectedQ.size() == 0)
			begin
				$display("done rose with no accepted start pending");
				timingErrors++;
			end
			else
			begin
				checkProduct(nameQ.pop_front(), expectedQ.pop_front(), product);
			end
		end
		doneLast = done;
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial
	begin
		logic [31:0] rnd;
		int risesBefore;
		int assertionErrors;
		SC_STATEMACHINE_Reset_InHigh = 1'b1;
		start = 1'b0;
		operandA = '0;
		operandB = '0;
		repeat (3) @(negedge SC_STATEMACHINE_CLOCK_50);
		SC_STATEMACHINE_Reset_InHigh = 1'b0;
		@(negedge SC_STATEMACHINE_CLOCK_50);
		checkDone("afterReset", 1'b0, done);
		checkProduct("afterReset", '0, product);

		// Directed corners
		runProduct("zeroTimes37", 8'd0, 8'd37);
		runProduct("37TimesZero", 8'd37, 8'd0);
		runProduct("oneTimesOne", 8'd1, 8'd1);
		runProduct("maxTimesMax", 8'd255, 8'd255);
		runProduct("128TimesTwo", 8'd128, 8'd2);

		for (int i = 0; i < randomPairs; i++)
		begin
			rnd = $random(seed);
			runProduct($sformatf("random%0d", i), rnd[7:0], rnd[15:8]);
		end

		// Restart straight from done with a cleared accumulator
		runProduct("firstOfPair", 8'd200, 8'd150);
		launchRun("secondOfPair", 8'd3, 8'd5);
		@(negedge SC_STATEMACHINE_CLOCK_50);
		checkProduct("accumulatorCleared", '0, product);
		checkDone("doneDropped", 1'b0, done);
		waitDone("secondOfPair");

		// Start pulse in mid-run must be ignored
		launchRun("busyFirst", 8'd99, 8'd77);
		risesBefore = doneRises;
		repeat (10) @(negedge SC_STATEMACHINE_CLOCK_50);
		operandA = 8'd11;
		operandB = 8'd13;
		start = 1'b1;
		@(negedge SC_STATEMACHINE_CLOCK_50);
		start = 1'b0;
		waitDone("busyFirst");
		repeat (maxRunCycles) @(negedge SC_STATEMACHINE_CLOCK_50);
		checkDone("busyDoneHeld", 1'b1, done);
		if (doneRises - risesBefore != 1)
		begin
			$display("done rose %0d times for one accepted start", doneRises - risesBefore);
			timingErrors++;
		end

		assertionErrors = dut_i.sequencer_i.controlChecks_i.violationCount;
		$display("Errors: %0d value, %0d timing, %0d assertion",
			valueErrors, timingErrors, assertionErrors);
		if (valueErrors + timingErrors + assertionErrors == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Hang guard sized from the run count
	initial
	begin
		#(runCount * maxRunCycles * clockPeriod);
		$display("Watchdog expired before all runs finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: sources.f
logic/multiplierPkg.sv
logic/registerBank.sv
logic/alu.sv
logic/shiftRegister.sv
logic/sequencer.sv
logic/multiplierTop.sv
dv/multiplierTop_assertions.sv
dv/multiplierTb.sv

// File: Makefile
TOP = multiplierTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)Sim
	./obj_dir/$(TOP)Sim +verilator+error+limit+1000 | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
